//--- common/commit_pkg.sv
package commit_pkg;

  // datapath and register file sizes
  localparam int WORD_SIZE    = 16;
  localparam int NUM_PHYS_REG = 32;
  localparam int NUM_ARCH_REG = 8;
  localparam int PHYS_REG_W   = $clog2(NUM_PHYS_REG);
  localparam int ARCH_REG_W   = $clog2(NUM_ARCH_REG);

  // tag width caps the buffer at 16 entries
  localparam int ROB_TAG_W    = 4;

  // NZCV, with N in the top bit
  localparam int NUM_FLAGS    = 4;
  localparam int flag_v       = 0;
  localparam int flag_c       = 1;
  localparam int flag_z       = 2;
  localparam int flag_n       = 3;

  typedef logic [WORD_SIZE-1:0]  word_t;
  typedef logic [PHYS_REG_W-1:0] phys_reg_t;
  typedef logic [ARCH_REG_W-1:0] arch_reg_t;
  typedef logic [ROB_TAG_W-1:0]  rob_tag_t;
  typedef logic [NUM_FLAGS-1:0]  flags_t;

  // condition codes, 15 is never
  typedef enum logic [3:0] {
    EQ, NE, CS, CC, MI, PL, VS, VC,
    HI, LS, GE, LT, GT, LE, AL, NV
  } cond_t;

  // handed over by rename
  typedef struct packed {
    logic      w_v;
    logic      is_store;
    logic      is_spec;
    logic      is_cond_branch;
    cond_t     bcc_op;
    arch_reg_t arch_dest;
    phys_reg_t alloc_reg;
    phys_reg_t freed_reg;
    flags_t    flag_mask;
    word_t     pc;
    word_t     predicted_pc;
  } rob_alloc_t;

  // one common data bus lane
  typedef struct packed {
    logic     valid;
    rob_tag_t rob_dest;
    flags_t   flags;
    word_t    result;
  } cdb_t;

  typedef struct packed {
    logic       valid;
    logic       wb;
    flags_t     flags;
    word_t      resolved_pc;
    rob_alloc_t instr;
  } rob_entry_t;

  // retirement record for the committed map
  typedef struct packed {
    logic      w_v;
    arch_reg_t arch_dest;
    phys_reg_t alloc_reg;
    phys_reg_t freed_reg;
  } commit_map_t;

endpackage

//--- rob/rob.sv
`timescale 1ns/1ps

module rob #(
  parameter int ROB_ENTRY = 8,
  parameter int NUM_FU    = 2
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    alloc_valid_i,
  input  commit_pkg::rob_alloc_t  alloc_entry_i,
  output logic                    alloc_ready_o,
  output commit_pkg::rob_tag_t    alloc_tag_o,
  input  commit_pkg::cdb_t        cdb_i [NUM_FU],
  input  logic                    mispredict_i,
  output commit_pkg::rob_entry_t  head_o,
  output logic                    head_ready_o,
  output logic                    commit_valid_o,
  output commit_pkg::commit_map_t commit_o,
  output logic                    flag_valid_o,
  output commit_pkg::flags_t      flag_mask_o,
  output commit_pkg::flags_t      flag_o,
  output logic                    sb_pop_o,
  output logic                    phys_valid_o,
  output commit_pkg::phys_reg_t   phys_clear_o,
  output commit_pkg::phys_reg_t   phys_set_o
);
  import commit_pkg::*;

  localparam int PTR_W = $clog2(ROB_ENTRY);
  localparam int CNT_W = $clog2(ROB_ENTRY + 1);

  // entry payload
  rob_alloc_t alloc_q    [ROB_ENTRY];
  flags_t     flags_q    [ROB_ENTRY];
  word_t      resolved_q [ROB_ENTRY];

  logic [ROB_ENTRY-1:0] valid_q;
  logic [ROB_ENTRY-1:0] wb_q;
  logic [PTR_W-1:0]     alloc_ptr_q;
  logic [PTR_W-1:0]     head_ptr_q;
  logic [CNT_W-1:0]     free_cnt_q;

  logic [PTR_W-1:0]     alloc_ptr_nxt;
  logic [PTR_W-1:0]     head_ptr_nxt;
  logic                 accept;
  logic                 retire;
  rob_alloc_t           head_instr;

  // per-entry bus hits
  logic [ROB_ENTRY-1:0] hit;
  flags_t               hit_flags  [ROB_ENTRY];
  word_t                hit_result [ROB_ENTRY];

  assign alloc_ptr_nxt = (alloc_ptr_q == PTR_W'(ROB_ENTRY - 1)) ? '0 : alloc_ptr_q + 1'b1;
  assign head_ptr_nxt  = (head_ptr_q == PTR_W'(ROB_ENTRY - 1)) ? '0 : head_ptr_q + 1'b1;

  assign alloc_ready_o = (free_cnt_q != '0) & ~mispredict_i;
  assign alloc_tag_o   = rob_tag_t'(alloc_ptr_q);
  assign accept        = alloc_valid_i & alloc_ready_o;

  // associative match of every lane against every live entry
  always_comb begin
    for (int i = 0; i < ROB_ENTRY; i++) begin
      hit[i]        = 1'b0;
      hit_flags[i]  = '0;
      hit_result[i] = '0;
      for (int j = 0; j < NUM_FU; j++) begin
        if (cdb_i[j].valid && cdb_i[j].rob_dest == rob_tag_t'(i) && valid_q[i] && !wb_q[i]) begin
          hit[i]        = 1'b1;
          hit_flags[i]  = cdb_i[j].flags;
          hit_result[i] = cdb_i[j].result;
        end
      end
    end
  end

  // head entry seen by branch resolution
  assign head_instr         = alloc_q[head_ptr_q];
  assign head_o.valid       = valid_q[head_ptr_q];
  assign head_o.wb          = wb_q[head_ptr_q];
  assign head_o.flags       = flags_q[head_ptr_q];
  assign head_o.resolved_pc = resolved_q[head_ptr_q];
  assign head_o.instr       = head_instr;

  assign head_ready_o = valid_q[head_ptr_q] & wb_q[head_ptr_q];
  assign retire       = head_ready_o & ~mispredict_i;

  // commit strobes for the retiring head
  assign commit_valid_o     = retire;
  assign commit_o.w_v       = head_instr.w_v;
  assign commit_o.arch_dest = head_instr.arch_dest;
  assign commit_o.alloc_reg = head_instr.alloc_reg;
  assign commit_o.freed_reg = head_instr.freed_reg;

  assign flag_valid_o = retire & (|head_instr.flag_mask);
  assign flag_mask_o  = head_instr.flag_mask;
  assign flag_o       = flags_q[head_ptr_q];

  assign sb_pop_o     = retire & head_instr.is_store;
  assign phys_valid_o = retire & head_instr.w_v & ~head_instr.is_store;
  assign phys_clear_o = head_instr.freed_reg;
  assign phys_set_o   = head_instr.alloc_reg;

  always_ff @(posedge clk_i) begin
    if (reset_i || mispredict_i) begin
      // a mispredict empties the whole buffer
      valid_q     <= '0;
      wb_q        <= '0;
      alloc_ptr_q <= '0;
      head_ptr_q  <= '0;
      free_cnt_q  <= CNT_W'(ROB_ENTRY);
    end else begin
      for (int i = 0; i < ROB_ENTRY; i++) begin
        if (hit[i]) begin
          wb_q[i] <= 1'b1;
        end
      end
      if (accept) begin
        valid_q[alloc_ptr_q] <= 1'b1;
        wb_q[alloc_ptr_q]    <= 1'b0;
        alloc_ptr_q          <= alloc_ptr_nxt;
      end
      if (retire) begin
        valid_q[head_ptr_q] <= 1'b0;
        wb_q[head_ptr_q]    <= 1'b0;
        head_ptr_q          <= head_ptr_nxt;
      end
      free_cnt_q <= free_cnt_q - CNT_W'(accept) + CNT_W'(retire);
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      alloc_q[alloc_ptr_q] <= alloc_entry_i;
    end
    for (int i = 0; i < ROB_ENTRY; i++) begin
      if (hit[i]) begin
        flags_q[i] <= hit_flags[i];
        // branches carry their resolved target on the bus
        if (alloc_q[i].is_spec) begin
          resolved_q[i] <= hit_result[i];
        end
      end
    end
  end

endmodule

//--- rob/branch_resolve.sv
`timescale 1ns/1ps

module branch_resolve (
  input  commit_pkg::rob_entry_t head_i,
  input  logic                   head_ready_i,
  input  commit_pkg::flags_t     flags_i,
  output logic                   mispredict_o,
  output commit_pkg::word_t      redirect_pc_o
);
  import commit_pkg::*;

  logic  n, z, c, v;
  logic  taken;
  word_t cond_pc;

  assign n = flags_i[flag_n];
  assign z = flags_i[flag_z];
  assign c = flags_i[flag_c];
  assign v = flags_i[flag_v];

  always_comb begin
    case (head_i.instr.bcc_op)
      EQ:      taken = z;
      NE:      taken = ~z;
      CS:      taken = c;
      CC:      taken = ~c;
      MI:      taken = n;
      PL:      taken = ~n;
      VS:      taken = v;
      VC:      taken = ~v;
      HI:      taken = c & ~z;
      LS:      taken = ~c | z;
      GE:      taken = (n == v);
      LT:      taken = (n != v);
      GT:      taken = ~z & (n == v);
      LE:      taken = z | (n != v);
      AL:      taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  // fall through to the next sequential pc when not taken
  assign cond_pc       = taken ? head_i.resolved_pc : head_i.instr.pc + 1'b1;
  assign redirect_pc_o = head_i.instr.is_cond_branch ? cond_pc : head_i.resolved_pc;

  assign mispredict_o = head_ready_i & head_i.instr.is_spec &
                        (head_i.instr.predicted_pc != redirect_pc_o);

endmodule

//--- logic/flag_register.sv
`timescale 1ns/1ps

module flag_register (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               flag_valid_i,
  input  commit_pkg::flags_t flag_mask_i,
  input  commit_pkg::flags_t flag_i,
  output commit_pkg::flags_t flags_o
);

  // committed NZCV, only masked bits change
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      flags_o <= '0;
    end else if (flag_valid_i) begin
      flags_o <= (flags_o & ~flag_mask_i) | (flag_i & flag_mask_i);
    end
  end

endmodule

//--- logic/commit_map.sv
`timescale 1ns/1ps

module commit_map (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    commit_valid_i,
  input  commit_pkg::commit_map_t commit_i,
  input  commit_pkg::arch_reg_t   rd_arch_i,
  output commit_pkg::phys_reg_t   rd_phys_o
);
  import commit_pkg::*;

  // architectural to physical, non-speculative
  phys_reg_t map_q [NUM_ARCH_REG];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      // identity mapping out of reset
      for (int r = 0; r < NUM_ARCH_REG; r++) begin
        map_q[r] <= phys_reg_t'(r);
      end
    end else if (commit_valid_i && commit_i.w_v) begin
      map_q[commit_i.arch_dest] <= commit_i.alloc_reg;
    end
  end

  assign rd_phys_o = map_q[rd_arch_i];

endmodule

//--- logic/commit_core.sv
`timescale 1ns/1ps

module commit_core #(
  parameter int ROB_ENTRY = 8,
  parameter int NUM_FU    = 2
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   alloc_valid_i,
  input  commit_pkg::rob_alloc_t alloc_entry_i,
  output logic                   alloc_ready_o,
  output commit_pkg::rob_tag_t   alloc_tag_o,
  input  commit_pkg::cdb_t       cdb_i [NUM_FU],
  output logic                   sb_pop_o,
  output logic                   phys_valid_o,
  output commit_pkg::phys_reg_t  phys_clear_o,
  output commit_pkg::phys_reg_t  phys_set_o,
  output logic                   mispredict_o,
  output commit_pkg::word_t      redirect_pc_o,
  output commit_pkg::flags_t     flags_o,
  input  commit_pkg::arch_reg_t  map_rd_arch_i,
  output commit_pkg::phys_reg_t  map_rd_phys_o
);
  import commit_pkg::*;

  rob_entry_t  head;
  logic        head_ready;
  logic        commit_valid;
  commit_map_t commit;
  logic        flag_valid;
  flags_t      flag_mask;
  flags_t      flag_new;

  rob #(
    .ROB_ENTRY (ROB_ENTRY),
    .NUM_FU    (NUM_FU)
  ) u_rob (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .alloc_valid_i  (alloc_valid_i),
    .alloc_entry_i  (alloc_entry_i),
    .alloc_ready_o  (alloc_ready_o),
    .alloc_tag_o    (alloc_tag_o),
    .cdb_i          (cdb_i),
    .mispredict_i   (mispredict_o),
    .head_o         (head),
    .head_ready_o   (head_ready),
    .commit_valid_o (commit_valid),
    .commit_o       (commit),
    .flag_valid_o   (flag_valid),
    .flag_mask_o    (flag_mask),
    .flag_o         (flag_new),
    .sb_pop_o       (sb_pop_o),
    .phys_valid_o   (phys_valid_o),
    .phys_clear_o   (phys_clear_o),
    .phys_set_o     (phys_set_o)
  );

  // conditional branches resolve against the committed flags
  branch_resolve u_branch_resolve (
    .head_i        (head),
    .head_ready_i  (head_ready),
    .flags_i       (flags_o),
    .mispredict_o  (mispredict_o),
    .redirect_pc_o (redirect_pc_o)
  );

  flag_register u_flag_register (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .flag_valid_i (flag_valid),
    .flag_mask_i  (flag_mask),
    .flag_i       (flag_new),
    .flags_o      (flags_o)
  );

  commit_map u_commit_map (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .commit_valid_i (commit_valid),
    .commit_i       (commit),
    .rd_arch_i      (map_rd_arch_i),
    .rd_phys_o      (map_rd_phys_o)
  );

endmodule

//--- testbench/commit_core_tb.sv
`timescale 1ns/1ps

module commit_core_tb;
  import commit_pkg::*;

  localparam int ENTRIES = 4;
  localparam int LIMIT   = 50;

  typedef enum logic [2:0] {
    S_ALLOC, S_BUS, S_RETIRE, S_FULL, S_READY, S_QUIET, S_MAP
  } step_kind_t;

  // one row of the stimulus table
  typedef struct packed {
    step_kind_t kind;
    rob_alloc_t ins;
    logic       lane;
    rob_tag_t   tag;
    flags_t     flags;
    word_t      target;
    logic [3:0] count;
  } step_t;

  logic        clk_i;
  logic        reset_i;
  logic        alloc_valid_i;
  rob_alloc_t  alloc_entry_i;
  logic        alloc_ready_o;
  rob_tag_t    alloc_tag_o;
  cdb_t        cdb [2];
  logic        sb_pop_o;
  logic        phys_valid_o;
  phys_reg_t   phys_clear_o;
  phys_reg_t   phys_set_o;
  logic        mispredict_o;
  word_t       redirect_pc_o;
  flags_t      flags_o;
  arch_reg_t   map_rd_arch_i;
  phys_reg_t   map_rd_phys_o;

  step_t              steps [$];
  // reference model of the buffer, flags and committed map
  rob_alloc_t         m_ent [ENTRIES];
  word_t              m_res [ENTRIES];
  flags_t             m_fl  [ENTRIES];
  logic [ENTRIES-1:0] m_valid;
  int                 m_head;
  int                 m_tail;
  int                 m_cnt;
  flags_t             m_flags;
  phys_reg_t          m_map [NUM_ARCH_REG];
  int                 errors;
  int                 checks;
  logic               timed_out;
  integer             seed;

  commit_core #(
    .ROB_ENTRY (ENTRIES),
    .NUM_FU    (2)
  ) dut (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .alloc_valid_i (alloc_valid_i),
    .alloc_entry_i (alloc_entry_i),
    .alloc_ready_o (alloc_ready_o),
    .alloc_tag_o   (alloc_tag_o),
    .cdb_i         (cdb),
    .sb_pop_o      (sb_pop_o),
    .phys_valid_o  (phys_valid_o),
    .phys_clear_o  (phys_clear_o),
    .phys_set_o    (phys_set_o),
    .mispredict_o  (mispredict_o),
    .redirect_pc_o (redirect_pc_o),
    .flags_o       (flags_o),
    .map_rd_arch_i (map_rd_arch_i),
    .map_rd_phys_o (map_rd_phys_o)
  );

  always #10 clk_i = ~clk_i;

  function automatic logic cond_holds(input cond_t op, input flags_t f);
    logic base;
    case (op[3:1])
      3'd0:    base = f[flag_z];
      3'd1:    base = f[flag_c];
      3'd2:    base = f[flag_n];
      3'd3:    base = f[flag_v];
      3'd4:    base = f[flag_c] & ~f[flag_z];
      3'd5:    base = (f[flag_n] == f[flag_v]);
      3'd6:    base = ~f[flag_z] & (f[flag_n] == f[flag_v]);
      default: base = 1'b1;
    endcase
    // odd codes invert the even code below them so 15 never holds
    return op[0] ? ~base : base;
  endfunction

  function automatic rob_alloc_t alu_op(input arch_reg_t a, input phys_reg_t nr,
                                        input phys_reg_t old, input flags_t mask);
    rob_alloc_t r;
    r = '0;
    r.w_v       = 1'b1;
    r.arch_dest = a;
    r.alloc_reg = nr;
    r.freed_reg = old;
    r.flag_mask = mask;
    return r;
  endfunction

  function automatic rob_alloc_t store_op(input word_t pc);
    rob_alloc_t r;
    r = '0;
    r.is_store = 1'b1;
    r.pc       = pc;
    return r;
  endfunction

  // branch and link so a correct branch still shows a phys strobe
  function automatic rob_alloc_t branch_op(input logic is_cond, input cond_t op,
                                           input word_t pc, input word_t pred,
                                           input arch_reg_t a, input phys_reg_t nr,
                                           input phys_reg_t old);
    rob_alloc_t r;
    r = alu_op(a, nr, old, 4'b0000);
    r.is_spec        = 1'b1;
    r.is_cond_branch = is_cond;
    r.bcc_op         = op;
    r.pc             = pc;
    r.predicted_pc   = pred;
    return r;
  endfunction

  task automatic alloc_step(input rob_alloc_t ins);
    step_t s;
    s = '0;
    s.kind = S_ALLOC;
    s.ins  = ins;
    steps.push_back(s);
  endtask

  task automatic bus_step(input logic lane, input rob_tag_t tag, input flags_t fl,
                          input word_t target);
    step_t s;
    s = '0;
    s.kind   = S_BUS;
    s.lane   = lane;
    s.tag    = tag;
    s.flags  = fl;
    s.target = target;
    steps.push_back(s);
  endtask

  task automatic check_step(input step_kind_t kind, input logic [3:0] count);
    step_t s;
    s = '0;
    s.kind  = kind;
    s.count = count;
    steps.push_back(s);
  endtask

  task automatic compare(input int idx, input string name, input logic [31:0] got,
                         input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH step %0d %s: got %h expected %h", idx, name, got, exp);
    end
  endtask

  task automatic expect_idle(input int idx);
    compare(idx, "phys_valid_o", 32'(phys_valid_o), 32'd0);
    compare(idx, "sb_pop_o", 32'(sb_pop_o), 32'd0);
    compare(idx, "mispredict_o", 32'(mispredict_o), 32'd0);
  endtask

  task automatic build_table();
    // three writers written back youngest first on alternating lanes
    alloc_step(alu_op(3'd1, 5'd8, 5'd1, 4'b0000));
    alloc_step(alu_op(3'd2, 5'd9, 5'd2, 4'b0000));
    alloc_step(alu_op(3'd3, 5'd10, 5'd3, 4'b0000));
    bus_step(1'b1, 4'd2, 4'b0000, 16'h0);
    bus_step(1'b0, 4'd1, 4'b0000, 16'h0);
    bus_step(1'b1, 4'd0, 4'b0000, 16'h0);
    for (int k = 0; k < 3; k++) begin
      check_step(S_RETIRE, 4'd0);
    end
    check_step(S_MAP, 4'd0);
    // fill the buffer starting at tag 3
    alloc_step(alu_op(3'd4, 5'd11, 5'd4, 4'b0000));
    alloc_step(alu_op(3'd5, 5'd12, 5'd5, 4'b0000));
    alloc_step(alu_op(3'd1, 5'd13, 5'd8, 4'b0000));
    alloc_step(alu_op(3'd6, 5'd14, 5'd6, 4'b0000));
    check_step(S_FULL, 4'd2);
    bus_step(1'b0, 4'd3, 4'b0000, 16'h0);
    check_step(S_RETIRE, 4'd0);
    check_step(S_READY, 4'd0);
    bus_step(1'b1, 4'd2, 4'b0000, 16'h0);
    bus_step(1'b0, 4'd1, 4'b0000, 16'h0);
    bus_step(1'b1, 4'd0, 4'b0000, 16'h0);
    for (int k = 0; k < 3; k++) begin
      check_step(S_RETIRE, 4'd0);
    end
    // masked flag updates Z|C then N|Z
    alloc_step(alu_op(3'd7, 5'd15, 5'd7, 4'b0110));
    bus_step(1'b0, 4'd3, 4'b1111, 16'h0);
    check_step(S_RETIRE, 4'd0);
    alloc_step(alu_op(3'd2, 5'd16, 5'd9, 4'b1100));
    bus_step(1'b1, 4'd0, 4'b1001, 16'h0);
    check_step(S_RETIRE, 4'd0);
    check_step(S_MAP, 4'd0);
    alloc_step(store_op(16'h0040));
    bus_step(1'b0, 4'd1, 4'b0000, 16'h0);
    check_step(S_RETIRE, 4'd0);
    check_step(S_MAP, 4'd0);
    // HI correct and LT mispredicted with two younger writers behind them
    alloc_step(branch_op(1'b1, HI, 16'h0100, 16'h0180, 3'd7, 5'd17, 5'd15));
    alloc_step(branch_op(1'b1, LT, 16'h0110, 16'h0111, 3'd7, 5'd18, 5'd17));
    alloc_step(alu_op(3'd3, 5'd19, 5'd10, 4'b1111));
    alloc_step(alu_op(3'd4, 5'd20, 5'd11, 4'b0000));
    bus_step(1'b1, 4'd0, 4'b0101, 16'h0);
    bus_step(1'b0, 4'd3, 4'b0000, 16'h0150);
    bus_step(1'b1, 4'd2, 4'b0000, 16'h0180);
    check_step(S_RETIRE, 4'd0);
    check_step(S_RETIRE, 4'd0);
    // late bus writes for the flushed entries
    bus_step(1'b0, 4'd1, 4'b1111, 16'h0);
    bus_step(1'b1, 4'd0, 4'b1111, 16'h0);
    check_step(S_QUIET, 4'd4);
    check_step(S_READY, 4'd0);
    check_step(S_MAP, 4'd0);
    // EQ sees Z set by the writer that retires just before it
    alloc_step(alu_op(3'd5, 5'd21, 5'd12, 4'b0100));
    alloc_step(branch_op(1'b1, EQ, 16'h0200, 16'h0240, 3'd6, 5'd22, 5'd14));
    bus_step(1'b0, 4'd1, 4'b0000, 16'h0240);
    bus_step(1'b1, 4'd0, 4'b0100, 16'h0);
    check_step(S_RETIRE, 4'd0);
    check_step(S_RETIRE, 4'd0);
    alloc_step(branch_op(1'b1, GE, 16'h0300, 16'h0380, 3'd1, 5'd23, 5'd13));
    bus_step(1'b0, 4'd2, 4'b0000, 16'h0380);
    check_step(S_RETIRE, 4'd0);
    // unconditional speculative branch with a wrong target
    alloc_step(branch_op(1'b0, AL, 16'h0400, 16'h0420, 3'd2, 5'd24, 5'd16));
    bus_step(1'b1, 4'd0, 4'b0000, 16'h0430);
    check_step(S_RETIRE, 4'd0);
    alloc_step(branch_op(1'b1, NV, 16'h0500, 16'h0501, 3'd3, 5'd25, 5'd19));
    alloc_step(branch_op(1'b1, VC, 16'h0510, 16'h05a0, 3'd4, 5'd26, 5'd20));
    bus_step(1'b1, 4'd1, 4'b0000, 16'h05a0);
    bus_step(1'b0, 4'd0, 4'b0000, 16'h05f0);
    check_step(S_RETIRE, 4'd0);
    check_step(S_RETIRE, 4'd0);
    check_step(S_MAP, 4'd0);
    check_step(S_QUIET, 4'd2);
  endtask

  task automatic run_step(input int idx, input step_t s);
    rob_alloc_t e;
    word_t      good_pc;
    logic       mis;
    logic       want_phys;
    int         waited;
    waited = 0;
    case (s.kind)
      S_ALLOC: begin
        expect_idle(idx);
        while (!alloc_ready_o && waited < LIMIT) begin
          @(negedge clk_i);
          waited++;
        end
        if (!alloc_ready_o) begin
          timed_out = 1'b1;
          $display("timeout at step %0d: alloc_ready_o never rose", idx);
        end else begin
          compare(idx, "alloc_tag_o", 32'(alloc_tag_o), 32'(m_tail));
          alloc_valid_i   = 1'b1;
          alloc_entry_i   = s.ins;
          m_ent[m_tail]   = s.ins;
          m_valid[m_tail] = 1'b1;
          m_tail          = (m_tail + 1) % ENTRIES;
          m_cnt++;
          @(negedge clk_i);
          alloc_valid_i = 1'b0;
        end
      end
      S_BUS: begin
        expect_idle(idx);
        cdb[s.lane].valid    = 1'b1;
        cdb[s.lane].rob_dest = s.tag;
        cdb[s.lane].flags    = s.flags;
        cdb[s.lane].result   = word_t'($random(seed));
        if (m_valid[s.tag]) begin
          // branches put their resolved target on the bus
          if (m_ent[s.tag].is_spec) begin
            cdb[s.lane].result = s.target;
          end
          m_fl[s.tag]  = s.flags;
          m_res[s.tag] = cdb[s.lane].result;
        end
        @(negedge clk_i);
        cdb[s.lane] = '0;
      end
      S_RETIRE: begin
        while (!(phys_valid_o || sb_pop_o || mispredict_o) && waited < LIMIT) begin
          @(negedge clk_i);
          waited++;
        end
        if (!(phys_valid_o || sb_pop_o || mispredict_o)) begin
          timed_out = 1'b1;
          $display("timeout at step %0d: no retirement was seen", idx);
        end else begin
          e       = m_ent[m_head];
          good_pc = m_res[m_head];
          if (e.is_cond_branch && !cond_holds(e.bcc_op, m_flags)) begin
            good_pc = e.pc + 16'd1;
          end
          mis       = e.is_spec && (e.predicted_pc != good_pc);
          want_phys = !mis && e.w_v && !e.is_store;
          compare(idx, "mispredict_o", 32'(mispredict_o), 32'(mis));
          compare(idx, "phys_valid_o", 32'(phys_valid_o), 32'(want_phys));
          compare(idx, "sb_pop_o", 32'(sb_pop_o), 32'(!mis && e.is_store));
          if (mis) begin
            compare(idx, "redirect_pc_o", 32'(redirect_pc_o), 32'(good_pc));
            compare(idx, "alloc_ready_o", 32'(alloc_ready_o), 32'd0);
            @(negedge clk_i);
            compare(idx, "alloc_tag_o", 32'(alloc_tag_o), 32'd0);
            compare(idx, "alloc_ready_o", 32'(alloc_ready_o), 32'd1);
            m_valid = '0;
            m_head  = 0;
            m_tail  = 0;
            m_cnt   = 0;
          end else begin
            if (want_phys) begin
              compare(idx, "phys_set_o", 32'(phys_set_o), 32'(e.alloc_reg));
              compare(idx, "phys_clear_o", 32'(phys_clear_o), 32'(e.freed_reg));
            end
            for (int f = 0; f < NUM_FLAGS; f++) begin
              if (e.flag_mask[f]) begin
                m_flags[f] = m_fl[m_head][f];
              end
            end
            if (e.w_v) begin
              m_map[e.arch_dest] = e.alloc_reg;
            end
            m_valid[m_head] = 1'b0;
            m_head          = (m_head + 1) % ENTRIES;
            m_cnt--;
            map_rd_arch_i = e.arch_dest;
            @(negedge clk_i);
            compare(idx, "flags_o", 32'(flags_o), 32'(m_flags));
            compare(idx, "map_rd_phys_o", 32'(map_rd_phys_o), 32'(m_map[e.arch_dest]));
          end
        end
      end
      S_FULL: begin
        expect_idle(idx);
        compare(idx, "alloc_ready_o", 32'(alloc_ready_o), 32'(m_cnt < ENTRIES));
        // source keeps valid up while the buffer is full
        alloc_valid_i = 1'b1;
        alloc_entry_i = s.ins;
        repeat (s.count) begin
          @(negedge clk_i);
          compare(idx, "alloc_ready_o", 32'(alloc_ready_o), 32'(m_cnt < ENTRIES));
          compare(idx, "alloc_tag_o", 32'(alloc_tag_o), 32'(m_tail));
        end
        alloc_valid_i = 1'b0;
      end
      S_READY: begin
        expect_idle(idx);
        compare(idx, "alloc_ready_o", 32'(alloc_ready_o), 32'(m_cnt < ENTRIES));
        compare(idx, "alloc_tag_o", 32'(alloc_tag_o), 32'(m_tail));
      end
      S_QUIET: begin
        repeat (s.count) begin
          expect_idle(idx);
          @(negedge clk_i);
        end
      end
      default: begin
        expect_idle(idx);
        for (int r = 0; r < NUM_ARCH_REG; r++) begin
          map_rd_arch_i = arch_reg_t'(r);
          @(negedge clk_i);
          compare(idx, "map_rd_phys_o", 32'(map_rd_phys_o), 32'(m_map[r]));
        end
      end
    endcase
  endtask

  initial begin
    clk_i         = 1'b0;
    reset_i       = 1'b1;
    alloc_valid_i = 1'b0;
    alloc_entry_i = '0;
    cdb[0]        = '0;
    cdb[1]        = '0;
    map_rd_arch_i = '0;
    errors        = 0;
    checks        = 0;
    timed_out     = 1'b0;
    seed          = 65043;
    m_valid       = '0;
    m_head        = 0;
    m_tail        = 0;
    m_cnt         = 0;
    m_flags       = '0;
    for (int r = 0; r < NUM_ARCH_REG; r++) begin
      m_map[r] = phys_reg_t'(r);
    end
    build_table();
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    // step -1 marks the checks right after reset
    expect_idle(-1);
    compare(-1, "alloc_ready_o", 32'(alloc_ready_o), 32'd1);
    compare(-1, "alloc_tag_o", 32'(alloc_tag_o), 32'd0);
    compare(-1, "flags_o", 32'(flags_o), 32'd0);
    for (int i = 0; i < steps.size() && !timed_out; i++) begin
      run_step(i, steps[i]);
    end
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- src.f
common/commit_pkg.sv
rob/rob.sv
rob/branch_resolve.sv
logic/flag_register.sv
logic/commit_map.sv
logic/commit_core.sv
testbench/commit_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the commit core testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f src.f --top-module commit_core_tb -Mdir obj_dir; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vcommit_core_tb > sim.log 2>&1
status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qF "*** TEST PASSED ***" sim.log; then
  exit 0
fi

echo "pass message not found in sim.log"
exit 1
